//--- hw/rv_core_pkg.sv
package rv_core_pkg;

    // Datapath and register file widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Memory sizes in 32-bit words
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_AW    = 6;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // RV32I major opcodes known to the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // Writeback source, NONE leaves the register file untouched
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_PC4  = 2'd2,
        WB_NONE = 2'd3
    } wb_sel_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   op1;
        logic [XLEN-1:0]   op2;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rd;
        alu_op_e           alu_op;
        wb_sel_e           wb_sel;
        logic              mem_wen;
        logic [XLEN-1:0]   next_pc;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rd;
        wb_sel_e           wb_sel;
        logic              mem_wen;
        logic [XLEN-1:0]   next_pc;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   load_data;
        logic [REG_AW-1:0] rd;
        wb_sel_e           wb_sel;
        logic [XLEN-1:0]   next_pc;
    } mem_wb_t;

    // One record per retired instruction
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        logic [REG_AW-1:0] rd;
        logic              rd_we;
        logic [XLEN-1:0]   rd_data;
        logic [XLEN-1:0]   next_pc;
    } retire_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [rv_core_pkg::REG_AW-1:0] raddr1_i,
    input  logic [rv_core_pkg::REG_AW-1:0] raddr2_i,
    input  logic                           we_i,
    input  logic [rv_core_pkg::REG_AW-1:0] waddr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   wdata_i,
    output logic [rv_core_pkg::XLEN-1:0]   rdata1_o,
    output logic [rv_core_pkg::XLEN-1:0]   rdata2_o
);

    logic [rv_core_pkg::XLEN-1:0] regs [2**rv_core_pkg::REG_AW];

    // x0 is never written, so it stays zero after reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**rv_core_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

//--- hw/rv_ifu.sv
`timescale 1ns/1ps

module rv_ifu (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            pc_wen_i,
    input  logic [rv_core_pkg::XLEN-1:0]    next_pc_i,
    input  logic                            imem_we_i,
    input  logic [rv_core_pkg::IMEM_AW-1:0] imem_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]    imem_wdata_i,
    output rv_core_pkg::if_id_t             if_id_o
);

    logic [rv_core_pkg::XLEN-1:0]    imem [rv_core_pkg::IMEM_DEPTH];
    logic [rv_core_pkg::XLEN-1:0]    pc_q;
    logic                            fetch_q;
    logic [rv_core_pkg::IMEM_AW-1:0] fetch_idx;

    // Program load port
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= rv_core_pkg::RESET_PC;
        end else if (pc_wen_i) begin
            pc_q <= next_pc_i;
        end
    end

    // One fetch right after reset and one after every retire
    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_q <= 1'b1;
        end else begin
            fetch_q <= pc_wen_i;
        end
    end

    // Upper PC bits wrap onto the word index
    assign fetch_idx = pc_q[rv_core_pkg::IMEM_AW+1:2];

    always_comb begin
        if_id_o.valid = fetch_q && !rst_i;
        if_id_o.pc    = pc_q;
        if_id_o.inst  = imem[fetch_idx];
    end

endmodule

//--- hw/rv_idu.sv
`timescale 1ns/1ps

module rv_idu (
    input  logic                           clk,
    input  logic                           rst_i,
    input  rv_core_pkg::if_id_t            if_id_i,
    input  logic [rv_core_pkg::XLEN-1:0]   rdata1_i,
    input  logic [rv_core_pkg::XLEN-1:0]   rdata2_i,
    output logic [rv_core_pkg::REG_AW-1:0] raddr1_o,
    output logic [rv_core_pkg::REG_AW-1:0] raddr2_o,
    output rv_core_pkg::id_ex_t            id_ex_o
);

    logic [rv_core_pkg::XLEN-1:0] inst;
    rv_core_pkg::opcode_e         opcode;
    logic [2:0]                   funct3;
    logic [rv_core_pkg::XLEN-1:0] imm_i;
    logic [rv_core_pkg::XLEN-1:0] imm_s;
    logic [rv_core_pkg::XLEN-1:0] imm_b;
    logic [rv_core_pkg::XLEN-1:0] imm_u;
    logic [rv_core_pkg::XLEN-1:0] imm_j;
    logic [rv_core_pkg::XLEN-1:0] pc_plus4;
    logic                         rs_equal;
    rv_core_pkg::id_ex_t          dec;
    rv_core_pkg::id_ex_t          id_ex_q;

    assign inst     = if_id_i.inst;
    assign opcode   = rv_core_pkg::opcode_e'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign raddr1_o = inst[19:15];
    assign raddr2_o = inst[24:20];

    // Immediates for the I, S, B, U and J formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign pc_plus4 = if_id_i.pc + 32'd4;
    assign rs_equal = (rdata1_i == rdata2_i);

    always_comb begin
        // Defaults give a no-op that falls through to PC+4
        dec.valid    = if_id_i.valid;
        dec.pc       = if_id_i.pc;
        dec.inst     = inst;
        dec.op1      = rdata1_i;
        dec.op2      = rdata2_i;
        dec.rs2_data = rdata2_i;
        dec.rd       = inst[11:7];
        dec.alu_op   = rv_core_pkg::ALU_ADD;
        dec.wb_sel   = rv_core_pkg::WB_NONE;
        dec.mem_wen  = 1'b0;
        dec.next_pc  = pc_plus4;

        case (opcode)
            rv_core_pkg::OPC_OP: begin
                dec.wb_sel = rv_core_pkg::WB_ALU;
                case (funct3)
                    3'b000: dec.alu_op = inst[30] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b010: dec.alu_op = rv_core_pkg::ALU_SLT;
                    3'b100: dec.alu_op = rv_core_pkg::ALU_XOR;
                    3'b110: dec.alu_op = rv_core_pkg::ALU_OR;
                    3'b111: dec.alu_op = rv_core_pkg::ALU_AND;
                    default: dec.wb_sel = rv_core_pkg::WB_NONE;
                endcase
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // ADDI only
                dec.op2 = imm_i;
                if (funct3 == 3'b000) begin
                    dec.wb_sel = rv_core_pkg::WB_ALU;
                end
            end
            rv_core_pkg::OPC_LUI: begin
                dec.op2    = imm_u;
                dec.alu_op = rv_core_pkg::ALU_PASS_B;
                dec.wb_sel = rv_core_pkg::WB_ALU;
            end
            rv_core_pkg::OPC_LOAD: begin
                dec.op2 = imm_i;
                if (funct3 == 3'b010) begin
                    dec.wb_sel = rv_core_pkg::WB_MEM;
                end
            end
            rv_core_pkg::OPC_STORE: begin
                dec.op2     = imm_s;
                dec.mem_wen = (funct3 == 3'b010);
            end
            rv_core_pkg::OPC_BRANCH: begin
                if ((funct3 == 3'b000 && rs_equal) || (funct3 == 3'b001 && !rs_equal)) begin
                    dec.next_pc = if_id_i.pc + imm_b;
                end
            end
            rv_core_pkg::OPC_JAL: begin
                dec.wb_sel  = rv_core_pkg::WB_PC4;
                dec.next_pc = if_id_i.pc + imm_j;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_q.valid <= 1'b0;
        end else if (if_id_i.valid) begin
            id_ex_q <= dec;
        end else begin
            id_ex_q.valid <= 1'b0;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- hw/rv_exu.sv
`timescale 1ns/1ps

module rv_exu (
    input  logic                 clk,
    input  logic                 rst_i,
    input  rv_core_pkg::id_ex_t  id_ex_i,
    output rv_core_pkg::ex_mem_t ex_mem_o
);

    logic [rv_core_pkg::XLEN-1:0] alu_res;
    logic                         slt_bit;
    rv_core_pkg::ex_mem_t         ex_mem_q;

    assign slt_bit = ($signed(id_ex_i.op1) < $signed(id_ex_i.op2));

    // Sum doubles as the data address for LW and SW
    always_comb begin
        case (id_ex_i.alu_op)
            rv_core_pkg::ALU_ADD:    alu_res = id_ex_i.op1 + id_ex_i.op2;
            rv_core_pkg::ALU_SUB:    alu_res = id_ex_i.op1 - id_ex_i.op2;
            rv_core_pkg::ALU_AND:    alu_res = id_ex_i.op1 & id_ex_i.op2;
            rv_core_pkg::ALU_OR:     alu_res = id_ex_i.op1 | id_ex_i.op2;
            rv_core_pkg::ALU_XOR:    alu_res = id_ex_i.op1 ^ id_ex_i.op2;
            rv_core_pkg::ALU_SLT:    alu_res = {{(rv_core_pkg::XLEN-1){1'b0}}, slt_bit};
            rv_core_pkg::ALU_PASS_B: alu_res = id_ex_i.op2;
            default:                 alu_res = id_ex_i.op1 + id_ex_i.op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_q.valid <= 1'b0;
        end else if (id_ex_i.valid) begin
            ex_mem_q.valid    <= 1'b1;
            ex_mem_q.pc       <= id_ex_i.pc;
            ex_mem_q.inst     <= id_ex_i.inst;
            ex_mem_q.result   <= alu_res;
            ex_mem_q.rs2_data <= id_ex_i.rs2_data;
            ex_mem_q.rd       <= id_ex_i.rd;
            ex_mem_q.wb_sel   <= id_ex_i.wb_sel;
            ex_mem_q.mem_wen  <= id_ex_i.mem_wen;
            ex_mem_q.next_pc  <= id_ex_i.next_pc;
        end else begin
            ex_mem_q.valid <= 1'b0;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

//--- hw/rv_mem.sv
`timescale 1ns/1ps

module rv_mem (
    input  logic                 clk,
    input  logic                 rst_i,
    input  rv_core_pkg::ex_mem_t ex_mem_i,
    output rv_core_pkg::mem_wb_t mem_wb_o
);

    logic [rv_core_pkg::XLEN-1:0]    dmem [rv_core_pkg::DMEM_DEPTH];
    logic [rv_core_pkg::DMEM_AW-1:0] word_idx;
    logic                            store_en;
    rv_core_pkg::mem_wb_t            mem_wb_q;

    // Byte address bits [7:2] pick the word, higher bits alias
    assign word_idx = ex_mem_i.result[rv_core_pkg::DMEM_AW+1:2];
    assign store_en = ex_mem_i.valid && ex_mem_i.mem_wen;

    // Contents survive reset
    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[word_idx] <= ex_mem_i.rs2_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_q.valid <= 1'b0;
        end else if (ex_mem_i.valid) begin
            mem_wb_q.valid     <= 1'b1;
            mem_wb_q.pc        <= ex_mem_i.pc;
            mem_wb_q.inst      <= ex_mem_i.inst;
            mem_wb_q.result    <= ex_mem_i.result;
            mem_wb_q.load_data <= dmem[word_idx];
            mem_wb_q.rd        <= ex_mem_i.rd;
            mem_wb_q.wb_sel    <= ex_mem_i.wb_sel;
            mem_wb_q.next_pc   <= ex_mem_i.next_pc;
        end else begin
            mem_wb_q.valid <= 1'b0;
        end
    end

    assign mem_wb_o = mem_wb_q;

endmodule

//--- hw/rv_wbu.sv
`timescale 1ns/1ps

module rv_wbu (
    input  logic                           clk,
    input  logic                           rst_i,
    input  rv_core_pkg::mem_wb_t           mem_wb_i,
    output logic                           rf_we_o,
    output logic [rv_core_pkg::REG_AW-1:0] rf_waddr_o,
    output logic [rv_core_pkg::XLEN-1:0]   rf_wdata_o,
    output logic                           pc_wen_o,
    output logic [rv_core_pkg::XLEN-1:0]   next_pc_o,
    output logic                           retire_valid_o,
    output rv_core_pkg::retire_t           retire_o
);

    logic [rv_core_pkg::XLEN-1:0] pc_plus4;
    logic [rv_core_pkg::XLEN-1:0] wdata;
    logic                         we;
    logic                         done_q;
    rv_core_pkg::retire_t         retire_q;

    assign pc_plus4 = mem_wb_i.pc + 32'd4;

    always_comb begin
        case (mem_wb_i.wb_sel)
            rv_core_pkg::WB_MEM: wdata = mem_wb_i.load_data;
            rv_core_pkg::WB_PC4: wdata = pc_plus4;
            default:             wdata = mem_wb_i.result;
        endcase
    end

    // No write for NONE or for x0
    assign we = mem_wb_i.valid && (mem_wb_i.wb_sel != rv_core_pkg::WB_NONE)
                && (mem_wb_i.rd != '0);

    assign rf_we_o    = we;
    assign rf_waddr_o = mem_wb_i.rd;
    assign rf_wdata_o = wdata;

    // Single pulse frees the IFU for the next fetch
    always_ff @(posedge clk) begin
        if (rst_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= mem_wb_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_i.valid) begin
            retire_q.pc      <= mem_wb_i.pc;
            retire_q.inst    <= mem_wb_i.inst;
            retire_q.rd      <= mem_wb_i.rd;
            retire_q.rd_we   <= we;
            retire_q.rd_data <= we ? wdata : '0;
            retire_q.next_pc <= mem_wb_i.next_pc;
        end
    end

    assign pc_wen_o       = done_q;
    assign next_pc_o      = retire_q.next_pc;
    assign retire_valid_o = done_q;
    assign retire_o       = retire_q;

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            imem_we_i,
    input  logic [rv_core_pkg::IMEM_AW-1:0] imem_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]    imem_wdata_i,
    output logic                            retire_valid_o,
    output rv_core_pkg::retire_t            retire_o
);

    // Stage hand-off
    rv_core_pkg::if_id_t  if_id;
    rv_core_pkg::id_ex_t  id_ex;
    rv_core_pkg::ex_mem_t ex_mem;
    rv_core_pkg::mem_wb_t mem_wb;

    // Register file ports
    logic [rv_core_pkg::REG_AW-1:0] rs1_addr;
    logic [rv_core_pkg::REG_AW-1:0] rs2_addr;
    logic [rv_core_pkg::XLEN-1:0]   rdata1;
    logic [rv_core_pkg::XLEN-1:0]   rdata2;
    logic                           rf_we;
    logic [rv_core_pkg::REG_AW-1:0] rf_waddr;
    logic [rv_core_pkg::XLEN-1:0]   rf_wdata;

    // PC update from writeback
    logic                         pc_wen;
    logic [rv_core_pkg::XLEN-1:0] next_pc;

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    rv_ifu u_ifu (
        .clk          (clk),
        .rst_i        (rst_i),
        .pc_wen_i     (pc_wen),
        .next_pc_i    (next_pc),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .if_id_o      (if_id)
    );

    rv_idu u_idu (
        .clk      (clk),
        .rst_i    (rst_i),
        .if_id_i  (if_id),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .raddr1_o (rs1_addr),
        .raddr2_o (rs2_addr),
        .id_ex_o  (id_ex)
    );

    rv_exu u_exu (
        .clk      (clk),
        .rst_i    (rst_i),
        .id_ex_i  (id_ex),
        .ex_mem_o (ex_mem)
    );

    rv_mem u_mem (
        .clk      (clk),
        .rst_i    (rst_i),
        .ex_mem_i (ex_mem),
        .mem_wb_o (mem_wb)
    );

    // Writeback closes the loop back to the IFU
    rv_wbu u_wbu (
        .clk            (clk),
        .rst_i          (rst_i),
        .mem_wb_i       (mem_wb),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .pc_wen_o       (pc_wen),
        .next_pc_o      (next_pc),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

//--- verification/rv_iss.svh
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

// Architectural state of the reference model
logic [31:0] model_regs [32];
logic [31:0] model_mem  [64];
logic [31:0] model_pc;

function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        model_mem[i] = '0;
    end
    model_pc = 32'd0;
endfunction

// Runs the instruction at model_pc, returns the retire record it should produce
function automatic rv_core_pkg::retire_t reference_step();
    rv_core_pkg::retire_t rec;
    logic [31:0]          inst;
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          imm_i;
    logic [31:0]          addr;
    logic [31:0]          value;
    logic [31:0]          next_pc;
    logic                 writes;
    logic                 taken;

    inst    = prog[model_pc[7:2]];
    a       = model_regs[inst[19:15]];
    b       = model_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    addr    = a + imm_i;
    value   = '0;
    writes  = 1'b0;
    next_pc = model_pc + 32'd4;
    case (inst[6:0])
        // Register-register ALU
        7'b0110011: begin
            writes = 1'b1;
            case (inst[14:12])
                3'b000:  value = inst[30] ? a - b : a + b;
                3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  value = a ^ b;
                3'b110:  value = a | b;
                3'b111:  value = a & b;
                default: writes = 1'b0;
            endcase
        end
        // ADDI
        7'b0010011: begin
            writes = (inst[14:12] == 3'b000);
            value  = a + imm_i;
        end
        // LUI
        7'b0110111: begin
            writes = 1'b1;
            value  = {inst[31:12], 12'b0};
        end
        // LW
        7'b0000011: begin
            writes = (inst[14:12] == 3'b010);
            value  = model_mem[addr[7:2]];
        end
        // SW, S-type offset
        7'b0100011: begin
            addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            if (inst[14:12] == 3'b010) begin
                model_mem[addr[7:2]] = b;
            end
        end
        // BEQ and BNE
        7'b1100011: begin
            taken = (inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b);
            if (taken) begin
                next_pc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
        end
        // JAL links PC+4
        7'b1101111: begin
            writes  = 1'b1;
            value   = model_pc + 32'd4;
            next_pc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: begin
        end
    endcase

    rec.pc      = model_pc;
    rec.inst    = inst;
    rec.rd      = inst[11:7];
    rec.rd_we   = writes && (inst[11:7] != 5'd0);
    rec.rd_data = rec.rd_we ? value : 32'd0;
    rec.next_pc = next_pc;
    if (rec.rd_we) begin
        model_regs[inst[11:7]] = value;
    end
    model_pc = next_pc;
    return rec;
endfunction

`endif

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int PROG_LEN     = 63;
    localparam int RAND_BASE    = 12;
    localparam int RETIRE_GAP   = 5;
    localparam int WATCHDOG_NS  = ((PROG_LEN + 10) * RETIRE_GAP + PROG_LEN + RESET_CYCLES + 2)
                                  * CLK_PERIOD;
    localparam logic [31:0] LAST_PC = 32'(4 * (PROG_LEN - 1));

    // Test indices
    localparam int T_RESET   = 0;
    localparam int T_ALU     = 1;
    localparam int T_X0      = 2;
    localparam int T_MEM     = 3;
    localparam int T_CTRL    = 4;
    localparam int T_TIMING  = 5;
    localparam int T_UNKNOWN = 6;
    localparam int NUM_TESTS = 7;

    logic                 clk;
    logic                 rst_i;
    logic                 imem_we_i;
    logic [5:0]           imem_addr_i;
    logic [31:0]          imem_wdata_i;
    logic                 retire_valid_o;
    rv_core_pkg::retire_t retire_o;

    logic [31:0] prog [64];
    logic [31:0] lfsr_state   = 32'hf7ce_f009;
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    int          cyc          = 0;
    int          expected_cyc = RETIRE_GAP;
    int          retired      = 0;
    logic        program_done = 1'b0;

    `include "rv_iss.svh"

    rv_core uut (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_we_i      (imem_we_i),
        .imem_addr_i    (imem_addr_i),
        .imem_wdata_i   (imem_wdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Four data words spread over the 256-byte window, all seeded before use
    function automatic logic [11:0] pool_offset(input logic [1:0] sel);
        logic [11:0] off;
        case (sel)
            2'd0:    off = 12'h000;
            2'd1:    off = 12'h044;
            2'd2:    off = 12'h088;
            default: off = 12'h0fc;
        endcase
        return off;
    endfunction

    function automatic void build_program();
        logic [3:0]  cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] offset;
        int          words;
        for (int k = 0; k < 5; k++) begin
            prog[k] = enc_i(12'(take_bits(12)), 5'd0, 3'b000, 5'(k + 1), 7'b0010011);
        end
        for (int k = 0; k < 4; k++) begin
            prog[5 + k] = enc_s(pool_offset(2'(k)), 5'(k + 1), 5'd0);
        end
        // x0 write, unknown opcode and a load, all before the first branch
        prog[9]  = enc_i(12'(take_bits(12)), 5'd1, 3'b000, 5'd0, 7'b0010011);
        prog[10] = {25'(take_bits(25)), 7'b0001011};
        prog[11] = enc_i(pool_offset(2'd0), 5'd0, 3'b010, 5'd6, 7'b0000011);
        for (int idx = RAND_BASE; idx < PROG_LEN - 1; idx++) begin
            cls    = 4'(take_bits(4));
            rd     = 5'(take_bits(3));
            rs1    = 5'(take_bits(3));
            rs2    = 5'(take_bits(3));
            offset = pool_offset(2'(take_bits(2)));
            words  = 1 + int'(take_bits(2));
            // Forward targets never pass the final jump
            if (idx + words > PROG_LEN - 1) begin
                words = PROG_LEN - 1 - idx;
            end
            case (cls)
                4'd0:         prog[idx] = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
                4'd1:         prog[idx] = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
                4'd2:         prog[idx] = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
                4'd3:         prog[idx] = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
                4'd4:         prog[idx] = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
                4'd5:         prog[idx] = enc_r(7'b0000000, rs2, rs1, 3'b010, rd);
                4'd6, 4'd7:   prog[idx] = enc_i(12'(take_bits(12)), rs1, 3'b000, rd, 7'b0010011);
                4'd8:         prog[idx] = {20'(take_bits(20)), rd, 7'b0110111};
                4'd9, 4'd10:  prog[idx] = enc_i(offset, 5'd0, 3'b010, rd, 7'b0000011);
                4'd11, 4'd12: prog[idx] = enc_s(offset, rs2, 5'd0);
                4'd13:        prog[idx] = enc_b(13'(words * 4), rs2, rs1, 3'b000);
                4'd14:        prog[idx] = enc_b(13'(words * 4), rs2, rs1, 3'b001);
                default:      prog[idx] = enc_j(21'(words * 4), rd);
            endcase
        end
        // Jump to self ends the program
        prog[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    endfunction

    function automatic int test_of(input logic [31:0] inst);
        int t;
        case (inst[6:0])
            7'b0110011, 7'b0010011, 7'b0110111: t = (inst[11:7] == 5'd0) ? T_X0 : T_ALU;
            7'b0000011, 7'b0100011:             t = T_MEM;
            7'b1100011, 7'b1101111:             t = T_CTRL;
            default:                            t = T_UNKNOWN;
        endcase
        return t;
    endfunction

    function automatic string test_name(input int t);
        string name;
        case (t)
            T_RESET:  name = "reset_quiet";
            T_ALU:    name = "alu_results";
            T_X0:     name = "x0_writes";
            T_MEM:    name = "load_store";
            T_CTRL:   name = "control_flow";
            T_TIMING: name = "retire_timing";
            default:  name = "unknown_opcode";
        endcase
        return name;
    endfunction

    task automatic check_field(input int test, input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks[test]++;
        assert (got === want) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            errors[test]++;
        end
    endtask

    // Compare each retire with the reference model
    initial begin
        rv_core_pkg::retire_t want;
        int                   test;
        while (!program_done) begin
            @(negedge clk);
            if (rst_i) begin
                check_field(T_RESET, "retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
            end else begin
                cyc++;
                if (retire_valid_o || cyc == expected_cyc) begin
                    checks[T_TIMING]++;
                    assert (retire_valid_o && cyc == expected_cyc) else begin
                        errors[T_TIMING]++;
                        if (retire_valid_o) begin
                            $display("mismatch at %0t: retire cycle got %0d expected %0d",
                                     $time, cyc, expected_cyc);
                        end else begin
                            $display("no retire in cycle %0d after reset", cyc);
                        end
                    end
                end
                if (retire_valid_o) begin
                    expected_cyc = cyc + RETIRE_GAP;
                    want         = reference_step();
                    test         = test_of(want.inst);
                    check_field(test, "retire_o.pc", retire_o.pc, want.pc);
                    check_field(test, "retire_o.inst", retire_o.inst, want.inst);
                    check_field(test, "retire_o.rd", {27'b0, retire_o.rd}, {27'b0, want.rd});
                    check_field(test, "retire_o.rd_we", {31'b0, retire_o.rd_we},
                                {31'b0, want.rd_we});
                    check_field(test, "retire_o.rd_data", retire_o.rd_data, want.rd_data);
                    check_field(test, "retire_o.next_pc", retire_o.next_pc, want.next_pc);
                    retired++;
                    program_done = (want.pc == LAST_PC);
                end
            end
        end
    end

    initial begin
        int total_checks;
        int total_errors;
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        build_program();
        reset_model();
        // Program load while the core sits in reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            imem_we_i    <= 1'b1;
            imem_addr_i  <= 6'(i);
            imem_wdata_i <= prog[i];
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_i <= 1'b0;
        $display("test %s: %0d checks, %0d errors", test_name(T_RESET), checks[T_RESET],
                 errors[T_RESET]);

        wait (program_done);
        total_checks = checks[T_RESET];
        total_errors = errors[T_RESET];
        for (int t = T_ALU; t < NUM_TESTS; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
            if (checks[t] == 0) begin
                $display("test %s ran no checks", test_name(t));
                total_errors++;
            end
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("%0d retired, %0d checks, %0d errors", retired, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the program length and the reset phase
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the program never reached its final jump", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- rv_core.f
+incdir+verification
hw/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_ifu.sv
hw/rv_idu.sv
hw/rv_exu.sv
hw/rv_mem.sv
hw/rv_wbu.sv
hw/rv_core.sv
verification/rv_core_tb.sv

//--- Makefile
# Verilator flow for rv_core

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --timescale 1ns/1ps --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
